//--- Bender.yml
package:
  name: ntt_clbu_pp_model

sources:
  # RTL in compile order
  - hw/ntt_model_pkg.sv
  - hw/ntt_clbu_front.sv
  - hw/ntt_latency_line.sv
  - hw/ntt_network_router.sv
  - hw/ntt_clbu_pp_model.sv

  # Testbench with its stimulus table header
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_ntt_clbu_pp_model.sv

//--- compile.f
+incdir+include
hw/ntt_model_pkg.sv
hw/ntt_clbu_front.sv
hw/ntt_latency_line.sv
hw/ntt_network_router.sv
hw/ntt_clbu_pp_model.sv
testbench/tb_ntt_clbu_pp_model.sv

//--- hw/ntt_clbu_front.sv
`timescale 1ns/100ps

module ntt_clbu_front #(
  parameter int S_INIT = ntt_model_pkg::S - 1,
  parameter int S_DEC  = 1
) (
  input  logic                 clk,
  input  logic                 s_rst_n,
  input  ntt_model_pkg::beat_t in_beat,
  input  logic                 in_avail,
  output ntt_model_pkg::beat_t tagged_beat
);

  // ------------------------------------------------------------
  // Local sizes
  // ------------------------------------------------------------
  // Stage counter must hold both the reload value and the step
  localparam int STG_MAX = (S_INIT > S_DEC) ? S_INIT : S_DEC;
  localparam int STG_W   = (STG_MAX > 1) ? $clog2(STG_MAX + 1) : 1;
  localparam int LVL_W   = (ntt_model_pkg::INTL_L > 1) ? $clog2(ntt_model_pkg::INTL_L) : 1;

  localparam logic [STG_W-1:0] STG_INIT = STG_W'(S_INIT);
  localparam logic [STG_W-1:0] STG_STEP = STG_W'(S_DEC);
  // First level kept in a forward last stage
  localparam logic [LVL_W-1:0] LS_LVL_MIN =
    LVL_W'(ntt_model_pkg::INTL_L - ntt_model_pkg::GLWE_K_P1);

  // ------------------------------------------------------------
  // Stage / level / direction counters
  // ------------------------------------------------------------
  logic [STG_W-1:0] stg_q;
  logic [STG_W-1:0] stg_d;
  logic [LVL_W-1:0] lvl_q;
  logic [LVL_W-1:0] lvl_d;
  logic             bwd_q;
  logic             bwd_d;
  logic             batch_end;
  logic             stg_wrap;
  logic             last_stg;

  // Batch closes on an avail beat flagged eob
  assign batch_end = in_avail & in_beat.eob;
  // Not enough stages left for another step, reload
  assign stg_wrap  = (stg_q < STG_STEP);
  // Stage zero is the last stage of the pass
  assign last_stg  = (stg_q == '0);

  always_comb begin
    stg_d = stg_q;
    bwd_d = bwd_q;
    if (batch_end) begin
      if (stg_wrap) begin
        // End of pass, start over and flip direction
        stg_d = STG_INIT;
        bwd_d = ~bwd_q;
      end else begin
        stg_d = stg_q - STG_STEP;
      end
    end
  end

  // Level index runs over the interleave levels of a stage
  always_comb begin
    lvl_d = lvl_q;
    if (in_avail) begin
      lvl_d = in_beat.eol ? '0 : lvl_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      stg_q <= STG_INIT;
      lvl_q <= '0;
      bwd_q <= 1'b0;
    end else begin
      stg_q <= stg_d;
      lvl_q <= lvl_d;
      bwd_q <= bwd_d;
    end
  end

  // ------------------------------------------------------------
  // Coefficient processing
  // ------------------------------------------------------------
  // Stand-in for the butterfly, only the value part moves
  ntt_model_pkg::coef_u [ntt_model_pkg::PSI-1:0][ntt_model_pkg::R-1:0] coef_inc;

  always_comb begin
    for (int p = 0; p < ntt_model_pkg::PSI; p++) begin
      for (int r = 0; r < ntt_model_pkg::R; r++) begin
        // Keep the whole word, tag included
        coef_inc[p][r].raw        = in_beat.data[p][r].raw;
        // Value wraps naturally at VAL_W bits
        coef_inc[p][r].fields.val = in_beat.data[p][r].fields.val + 1'b1;
      end
    end
  end

  // ------------------------------------------------------------
  // Destination tagging
  // ------------------------------------------------------------
  logic rs_dst;
  logic ls_dst;

  // Regular stage while the counter has not reached zero
  assign rs_dst = in_avail & ~last_stg;
  // Last stage keeps every level backward, only the top ones forward
  assign ls_dst = in_avail & last_stg & (bwd_q | (lvl_q >= LS_LVL_MIN));

  always_comb begin
    // Framing passes through untouched
    tagged_beat          = in_beat;
    tagged_beat.data     = coef_inc;
    // Incoming avail fields are overwritten here
    tagged_beat.rs_avail = rs_dst;
    tagged_beat.ls_avail = ls_dst;
    tagged_beat.ntt_bwd  = bwd_q;
  end

endmodule

//--- hw/ntt_clbu_pp_model.sv
`timescale 1ns/100ps

module ntt_clbu_pp_model #(
  // Stage counter start value
  parameter int S_INIT   = ntt_model_pkg::S - 1,
  // Stage counter step per batch
  parameter int S_DEC    = 1,
  // Butterfly latency
  parameter int CLBU_LAT = 6,
  // Post-process latency
  parameter int PP_LAT   = 3
) (
  input  logic                 clk,
  input  logic                 s_rst_n,

  // Input beat, one per cycle, no stall
  input  ntt_model_pkg::beat_t in_beat,
  input  logic                 in_avail,

  // Regular stage network
  output ntt_model_pkg::beat_t rs_beat,
  output logic                 rs_avail,
  // Last stage network, forward and backward
  output ntt_model_pkg::beat_t ls_beat,
  output logic                 ls_avail,
  // Backward last stage network
  output ntt_model_pkg::beat_t bwd_ls_beat,
  output logic                 bwd_ls_avail
);

  // ------------------------------------------------------------
  // Internal links
  // ------------------------------------------------------------
  ntt_model_pkg::beat_t tagged_beat;
  ntt_model_pkg::beat_t tap_rs;
  ntt_model_pkg::beat_t tap_ls_bwd;
  ntt_model_pkg::beat_t tap_ls_fwd;
  ntt_model_pkg::beat_t tap_ls_start;

  // ------------------------------------------------------------
  // Front end
  // ------------------------------------------------------------
  // Counters, value bump, routing decision
  ntt_clbu_front #(
    .S_INIT (S_INIT),
    .S_DEC  (S_DEC)
  ) u_front (
    .clk         (clk),
    .s_rst_n     (s_rst_n),
    .in_beat     (in_beat),
    .in_avail    (in_avail),
    .tagged_beat (tagged_beat)
  );

  // ------------------------------------------------------------
  // Latency line
  // ------------------------------------------------------------
  ntt_latency_line #(
    .CLBU_LAT (CLBU_LAT),
    .PP_LAT   (PP_LAT)
  ) u_line (
    .clk          (clk),
    .s_rst_n      (s_rst_n),
    .tagged_beat  (tagged_beat),
    .tap_rs       (tap_rs),
    .tap_ls_bwd   (tap_ls_bwd),
    .tap_ls_fwd   (tap_ls_fwd),
    .tap_ls_start (tap_ls_start)
  );

  // ------------------------------------------------------------
  // Router
  // ------------------------------------------------------------
  // Same counter settings decide the last-stage-only mode
  ntt_network_router #(
    .S_INIT (S_INIT),
    .S_DEC  (S_DEC)
  ) u_router (
    .tap_rs       (tap_rs),
    .tap_ls_bwd   (tap_ls_bwd),
    .tap_ls_fwd   (tap_ls_fwd),
    .tap_ls_start (tap_ls_start),
    .rs_beat      (rs_beat),
    .rs_avail     (rs_avail),
    .ls_beat      (ls_beat),
    .ls_avail     (ls_avail),
    .bwd_ls_beat  (bwd_ls_beat),
    .bwd_ls_avail (bwd_ls_avail)
  );

endmodule

//--- hw/ntt_latency_line.sv
`timescale 1ns/100ps

module ntt_latency_line #(
  parameter int CLBU_LAT = 6,
  parameter int PP_LAT   = 3
) (
  input  logic                 clk,
  input  logic                 s_rst_n,
  input  ntt_model_pkg::beat_t tagged_beat,
  output ntt_model_pkg::beat_t tap_rs,
  output ntt_model_pkg::beat_t tap_ls_bwd,
  output ntt_model_pkg::beat_t tap_ls_fwd,
  output ntt_model_pkg::beat_t tap_ls_start
);

  // ------------------------------------------------------------
  // Depths
  // ------------------------------------------------------------
  // Butterfly then post-process
  localparam int BWD_DEPTH = CLBU_LAT + PP_LAT;
  // Forward post-process accumulates over two more cycles
  localparam int FWD_DEPTH = BWD_DEPTH + 2;
  // Extra room so the first level of a forward batch is still held
  localparam int TOT_DEPTH = FWD_DEPTH + ntt_model_pkg::INTL_L;

  // ------------------------------------------------------------
  // Shift register
  // ------------------------------------------------------------
  // Entry k holds the beat that came in k+1 cycles ago
  ntt_model_pkg::beat_t [TOT_DEPTH-1:0] line_q;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      // Every avail flag down, line starts as all bubbles
      line_q <= '0;
    end else begin
      line_q <= {line_q[TOT_DEPTH-2:0], tagged_beat};
    end
  end

  // ------------------------------------------------------------
  // Taps
  // ------------------------------------------------------------
  // Regular stage output point
  assign tap_rs       = line_q[CLBU_LAT-1];
  // Backward last stage, no accumulation
  assign tap_ls_bwd   = line_q[BWD_DEPTH-1];
  // Forward last stage after accumulation
  assign tap_ls_fwd   = line_q[FWD_DEPTH-1];
  // INTL_L beats older than the forward tap
  // Source of the start flags of a forward batch
  assign tap_ls_start = line_q[TOT_DEPTH-1];

endmodule

//--- hw/ntt_model_pkg.sv
package ntt_model_pkg;

  // ------------------------------------------------------------
  // Core sizes
  // ------------------------------------------------------------
  // Parallel butterfly groups
  localparam int PSI       = 2;
  // Radix of each butterfly
  localparam int R         = 2;
  // Number of NTT stages
  localparam int S         = 4;
  // Interleave levels per stage
  localparam int INTL_L    = 4;
  // Last levels kept by a forward last stage
  localparam int GLWE_K_P1 = 2;
  // PBS identifier width
  localparam int BPBS_ID_W = 4;

  // ------------------------------------------------------------
  // Coefficient word
  // ------------------------------------------------------------
  // Full word width
  localparam int OP_W      = 32;
  // Value part, the low bits of the word
  localparam int VAL_W     = 16;
  // Tag part, whatever is left above the value
  localparam int TAG_W     = OP_W - VAL_W;

  // Tag in the upper bits, value in the lower bits
  typedef struct packed {
    logic [TAG_W-1:0] tag;
    logic [VAL_W-1:0] val;
  } coef_fields_t;

  // Same word seen as a plain vector or as tag/value
  typedef union packed {
    logic [OP_W-1:0] raw;
    coef_fields_t    fields;
  } coef_u;

  // ------------------------------------------------------------
  // Beat
  // ------------------------------------------------------------
  // One cycle of data plus framing and routing info
  typedef struct packed {
    // PSI x R coefficients, one per butterfly input
    coef_u [PSI-1:0][R-1:0] data;
    // Start / end of batch
    logic                   sob;
    logic                   eob;
    // Start / end of level
    logic                   sol;
    logic                   eol;
    // Start / end of stage
    logic                   sos;
    logic                   eos;
    // Which PBS the beat belongs to
    logic [BPBS_ID_W-1:0]   pbs_id;
    // Routing decision taken at the front end
    // rs_avail sends the beat to the regular stage network
    // ls_avail sends it to a last stage network
    logic                   rs_avail;
    logic                   ls_avail;
    // Direction of the pass that produced the beat
    logic                   ntt_bwd;
  } beat_t;

endpackage

//--- hw/ntt_network_router.sv
`timescale 1ns/100ps

module ntt_network_router #(
  parameter int S_INIT = ntt_model_pkg::S - 1,
  parameter int S_DEC  = 1
) (
  input  ntt_model_pkg::beat_t tap_rs,
  input  ntt_model_pkg::beat_t tap_ls_bwd,
  input  ntt_model_pkg::beat_t tap_ls_fwd,
  input  ntt_model_pkg::beat_t tap_ls_start,
  output ntt_model_pkg::beat_t rs_beat,
  output logic                 rs_avail,
  output ntt_model_pkg::beat_t ls_beat,
  output logic                 ls_avail,
  output ntt_model_pkg::beat_t bwd_ls_beat,
  output logic                 bwd_ls_avail
);

  // ------------------------------------------------------------
  // Mode
  // ------------------------------------------------------------
  // Model handles the last stage only
  // Counter never leaves a multiple of S, so every beat is last stage
  localparam bit PROC_LS_ONLY = ((S_INIT % ntt_model_pkg::S) == 0) &&
                                ((S_DEC % ntt_model_pkg::S) == 0);

  // ------------------------------------------------------------
  // Regular stage channel
  // ------------------------------------------------------------
  // Straight from the butterfly tap
  assign rs_beat  = tap_rs;
  assign rs_avail = tap_rs.rs_avail;

  // ------------------------------------------------------------
  // Last stage channel, forward and backward merged
  // ------------------------------------------------------------
  logic                 sel_bwd_ls;
  logic                 bwd_ls_hit;
  logic                 fwd_ls_hit;
  ntt_model_pkg::beat_t fwd_ls_beat;

  // Backward last stage beat at its tap
  assign bwd_ls_hit = tap_ls_bwd.ls_avail & tap_ls_bwd.ntt_bwd;
  // Forward last stage beat at its tap
  assign fwd_ls_hit = tap_ls_fwd.ls_avail & ~tap_ls_fwd.ntt_bwd;

  // Backward beats go on the merged channel unless a dedicated one exists
  assign sel_bwd_ls = PROC_LS_ONLY ? 1'b0 : bwd_ls_hit;

  always_comb begin
    fwd_ls_beat     = tap_ls_fwd;
    // Start flags are those of the first level of the batch
    fwd_ls_beat.sob = tap_ls_start.sob;
    fwd_ls_beat.sol = tap_ls_start.sol;
    fwd_ls_beat.sos = tap_ls_start.sos;
  end

  // Both taps can't be busy at once in a valid stream
  // backward wins the mux when it has a beat
  assign ls_beat  = sel_bwd_ls ? tap_ls_bwd : fwd_ls_beat;
  assign ls_avail = sel_bwd_ls ? bwd_ls_hit : fwd_ls_hit;

  // ------------------------------------------------------------
  // Backward only last stage channel
  // ------------------------------------------------------------
  // Data always shown, avail only in last-stage-only mode
  assign bwd_ls_beat  = tap_ls_bwd;
  assign bwd_ls_avail = PROC_LS_ONLY & bwd_ls_hit;

endmodule

//--- include/tb_ntt_vectors.svh
localparam int N_VEC = 33;

// Row bits: [15] avail, [14:9] sob eob sol eol sos eos, [8] force val all ones,
// [7:4] pbs_id, [3:0] idle cycles after the beat
function automatic logic [15:0] vector_row(input int idx);
  logic [15:0] row;
  row = '0;
  case (idx)
    // Forward pass, stage 3
    0:  row = {1'b1, 6'b101010, 1'b0, 4'd0, 4'd0};
    1:  row = {1'b1, 6'b000000, 1'b1, 4'd0, 4'd0};
    2:  row = {1'b1, 6'b000000, 1'b0, 4'd0, 4'd0};
    3:  row = {1'b1, 6'b010101, 1'b0, 4'd0, 4'd2};
    // Stage 2
    4:  row = {1'b1, 6'b101010, 1'b0, 4'd1, 4'd0};
    5:  row = {1'b1, 6'b000000, 1'b0, 4'd1, 4'd1};
    6:  row = {1'b1, 6'b000000, 1'b0, 4'd1, 4'd0};
    7:  row = {1'b1, 6'b010101, 1'b0, 4'd1, 4'd0};
    // Not avail, its eob and eol must be ignored
    8:  row = {1'b0, 6'b010101, 1'b0, 4'd1, 4'd1};
    // Stage 1
    9:  row = {1'b1, 6'b101010, 1'b0, 4'd2, 4'd0};
    10: row = {1'b1, 6'b000000, 1'b0, 4'd2, 4'd0};
    11: row = {1'b1, 6'b000000, 1'b1, 4'd2, 4'd0};
    12: row = {1'b1, 6'b010101, 1'b0, 4'd2, 4'd0};
    // Stage 0, only the top two levels leave
    13: row = {1'b1, 6'b101010, 1'b0, 4'd3, 4'd0};
    // Two idle cycles put level 2 exactly INTL_L cycles after level 0
    14: row = {1'b1, 6'b000000, 1'b0, 4'd3, 4'd2};
    15: row = {1'b1, 6'b000000, 1'b1, 4'd3, 4'd1};
    16: row = {1'b1, 6'b010101, 1'b0, 4'd3, 4'd3};
    // Backward pass, stage 3
    17: row = {1'b1, 6'b101010, 1'b0, 4'd4, 4'd0};
    18: row = {1'b1, 6'b000000, 1'b0, 4'd4, 4'd0};
    19: row = {1'b1, 6'b000000, 1'b0, 4'd4, 4'd0};
    20: row = {1'b1, 6'b010101, 1'b0, 4'd4, 4'd0};
    // Stage 2
    21: row = {1'b1, 6'b101010, 1'b0, 4'd5, 4'd0};
    22: row = {1'b1, 6'b000000, 1'b0, 4'd5, 4'd2};
    23: row = {1'b1, 6'b000000, 1'b1, 4'd5, 4'd0};
    24: row = {1'b1, 6'b010101, 1'b0, 4'd5, 4'd1};
    // Stage 1
    25: row = {1'b1, 6'b101010, 1'b0, 4'd6, 4'd0};
    26: row = {1'b1, 6'b000000, 1'b0, 4'd6, 4'd0};
    27: row = {1'b1, 6'b000000, 1'b0, 4'd6, 4'd0};
    28: row = {1'b1, 6'b010101, 1'b0, 4'd6, 4'd0};
    // Stage 0, every level leaves
    29: row = {1'b1, 6'b101010, 1'b1, 4'd7, 4'd0};
    30: row = {1'b1, 6'b000000, 1'b0, 4'd7, 4'd1};
    31: row = {1'b1, 6'b000000, 1'b0, 4'd7, 4'd0};
    32: row = {1'b1, 6'b010101, 1'b1, 4'd7, 4'd4};
    default: row = '0;
  endcase
  return row;
endfunction

//--- testbench/tb_ntt_clbu_pp_model.sv
`timescale 1ns/100ps

module tb_ntt_clbu_pp_model;

  // ------------------------------------------------------------
  // Run constants
  // ------------------------------------------------------------
  localparam int S_INIT     = ntt_model_pkg::S - 1;
  localparam int S_DEC      = 1;
  localparam int CLBU_LAT   = 6;
  localparam int PP_LAT     = 3;
  // Output depths, counted from the drive edge
  localparam int BWD_DEPTH  = CLBU_LAT + PP_LAT;
  localparam int FWD_DEPTH  = BWD_DEPTH + 2;
  localparam int TOT_DEPTH  = FWD_DEPTH + ntt_model_pkg::INTL_L;
  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 5;
  localparam int WD_MARGIN  = 20;
  localparam int MAX_CYC    = 256;
  localparam int SEED       = 40744;

  `include "tb_ntt_vectors.svh"

  logic                 clk;
  logic                 s_rst_n;
  ntt_model_pkg::beat_t in_beat;
  logic                 in_avail;
  ntt_model_pkg::beat_t rs_beat;
  logic                 rs_avail;
  ntt_model_pkg::beat_t ls_beat;
  logic                 ls_avail;
  ntt_model_pkg::beat_t bwd_ls_beat;
  logic                 bwd_ls_avail;

  // Expected front end output, indexed by drive cycle
  ntt_model_pkg::beat_t rec [0:MAX_CYC-1];
  // Drive cycle index, moves on the falling edge only
  int                   cyc;
  // Reference stage / level / direction
  int                   m_stage;
  int                   m_level;
  logic                 m_bwd;
  int                   val_errs;
  int                   avail_errs;
  int                   other_errs;
  int                   n_rs;
  int                   n_ls_fwd;
  int                   n_ls_bwd;

  ntt_clbu_pp_model #(
    .S_INIT   (S_INIT),
    .S_DEC    (S_DEC),
    .CLBU_LAT (CLBU_LAT),
    .PP_LAT   (PP_LAT)
  ) UUT (
    .clk          (clk),
    .s_rst_n      (s_rst_n),
    .in_beat      (in_beat),
    .in_avail     (in_avail),
    .rs_beat      (rs_beat),
    .rs_avail     (rs_avail),
    .ls_beat      (ls_beat),
    .ls_avail     (ls_avail),
    .bwd_ls_beat  (bwd_ls_beat),
    .bwd_ls_avail (bwd_ls_avail)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------
  // Value field plus one, wraps at VAL_W bits
  function automatic logic [ntt_model_pkg::VAL_W-1:0] bump_val(
    input logic [ntt_model_pkg::VAL_W-1:0] v
  );
    int unsigned t;
    t = v;
    t = (t + 1) % (1 << ntt_model_pkg::VAL_W);
    return t[ntt_model_pkg::VAL_W-1:0];
  endfunction

  // Cycles before the first drive look like bubbles
  function automatic ntt_model_pkg::beat_t rec_at(input int idx);
    if (idx < 0 || idx >= MAX_CYC) begin
      return '0;
    end
    return rec[idx];
  endfunction

  // Store what the line should hold for this cycle, then step the counters
  task automatic record_input(input ntt_model_pkg::beat_t b, input logic av);
    ntt_model_pkg::beat_t e;
    e = b;
    for (int p = 0; p < ntt_model_pkg::PSI; p++) begin
      for (int r = 0; r < ntt_model_pkg::R; r++) begin
        e.data[p][r].fields.val = bump_val(b.data[p][r].fields.val);
      end
    end
    e.ntt_bwd  = m_bwd;
    e.rs_avail = av && (m_stage != 0);
    // Backward keeps all levels, forward only the top GLWE_K_P1
    e.ls_avail = av && (m_stage == 0) &&
                 (m_bwd || m_level >= ntt_model_pkg::INTL_L - ntt_model_pkg::GLWE_K_P1);
    if (cyc < MAX_CYC) begin
      rec[cyc] = e;
    end
    if (av) begin
      if (b.eob) begin
        if (m_stage < S_DEC) begin
          m_stage = S_INIT;
          m_bwd   = !m_bwd;
        end else begin
          m_stage = m_stage - S_DEC;
        end
      end
      m_level = b.eol ? 0 : m_level + 1;
    end
  endtask

  task automatic drive_idle();
    @(posedge clk);
    in_beat  <= '0;
    in_avail <= 1'b0;
    record_input('0, 1'b0);
  endtask

  task automatic report_value(input string chan, input ntt_model_pkg::beat_t got,
                              input ntt_model_pkg::beat_t exp);
    val_errs++;
    $display("[ERROR] %0t: %s beat got %h expected %h", $time, chan, got, exp);
  endtask

  task automatic report_avail(input string chan, input logic expected);
    avail_errs++;
    if (expected) begin
      $display("%s channel: expected beat missing at cycle %0d", chan, cyc);
    end else begin
      $display("%s channel: unexpected beat at cycle %0d", chan, cyc);
    end
  endtask

  // ------------------------------------------------------------
  // Output checks, on the falling edge where outputs are settled
  // ------------------------------------------------------------
  always @(negedge clk) begin : check_outputs
    ntt_model_pkg::beat_t e_rs;
    ntt_model_pkg::beat_t e_bwd;
    ntt_model_pkg::beat_t e_fwd;
    ntt_model_pkg::beat_t e_start;
    ntt_model_pkg::beat_t e_ls;
    logic                 bwd_hit;
    logic                 fwd_hit;
    e_rs    = rec_at(cyc - CLBU_LAT);
    e_bwd   = rec_at(cyc - BWD_DEPTH);
    e_fwd   = rec_at(cyc - FWD_DEPTH);
    e_start = rec_at(cyc - TOT_DEPTH);

    if (rs_avail !== e_rs.rs_avail) begin
      report_avail("regular stage", e_rs.rs_avail);
    end else if (e_rs.rs_avail) begin
      n_rs++;
      if (rs_beat !== e_rs) begin
        report_value("regular stage", rs_beat, e_rs);
      end
    end

    bwd_hit = e_bwd.ls_avail && e_bwd.ntt_bwd;
    fwd_hit = e_fwd.ls_avail && !e_fwd.ntt_bwd;
    e_ls    = bwd_hit ? e_bwd : e_fwd;
    // Forward start flags belong to the beat INTL_L cycles older
    if (!bwd_hit) begin
      e_ls.sob = e_start.sob;
      e_ls.sol = e_start.sol;
      e_ls.sos = e_start.sos;
    end
    if (ls_avail !== (bwd_hit || fwd_hit)) begin
      report_avail("last stage", bwd_hit || fwd_hit);
    end else if (bwd_hit || fwd_hit) begin
      if (bwd_hit) begin
        n_ls_bwd++;
      end else begin
        n_ls_fwd++;
      end
      if (ls_beat !== e_ls) begin
        report_value("last stage", ls_beat, e_ls);
      end
    end

    // Dedicated backward channel stays silent in the default mode
    if (bwd_ls_avail !== 1'b0) begin
      report_avail("backward last stage", 1'b0);
    end
    if (bwd_hit && bwd_ls_beat !== e_bwd) begin
      report_value("backward last stage", bwd_ls_beat, e_bwd);
    end
    cyc = cyc + 1;
  end

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------
  initial begin
    logic [15:0]          row;
    ntt_model_pkg::beat_t drv;
    int                   seed_ret;
    int                   gap;
    clk        = 1'b0;
    s_rst_n    = 1'b0;
    in_beat    = '0;
    in_avail   = 1'b0;
    cyc        = 0;
    m_stage    = S_INIT;
    m_level    = 0;
    m_bwd      = 1'b0;
    val_errs   = 0;
    avail_errs = 0;
    other_errs = 0;
    n_rs       = 0;
    n_ls_fwd   = 0;
    n_ls_bwd   = 0;
    seed_ret   = $urandom(SEED);

    repeat (RST_CYCLES) begin
      drive_idle();
    end
    s_rst_n <= 1'b1;

    for (int i = 0; i < N_VEC; i++) begin
      row = vector_row(i);
      gap = row[3:0];
      drv = '0;
      for (int p = 0; p < ntt_model_pkg::PSI; p++) begin
        for (int r = 0; r < ntt_model_pkg::R; r++) begin
          drv.data[p][r].raw = $urandom();
          // Force all ones to hit the wrap
          if (row[8]) begin
            drv.data[p][r].fields.val = '1;
          end
        end
      end
      {drv.sob, drv.eob, drv.sol, drv.eol, drv.sos, drv.eos} = row[14:9];
      drv.pbs_id   = row[7:4];
      // Noise in the fields the front end overwrites
      drv.rs_avail = 1'($urandom());
      drv.ls_avail = 1'($urandom());
      drv.ntt_bwd  = 1'($urandom());
      @(posedge clk);
      in_beat  <= drv;
      in_avail <= row[15];
      record_input(drv, row[15]);
      repeat (gap) begin
        drive_idle();
      end
    end

    // Flush the whole line
    repeat (TOT_DEPTH + 2) begin
      drive_idle();
    end
    @(posedge clk);
    if (n_rs == 0 || n_ls_fwd == 0 || n_ls_bwd == 0) begin
      other_errs++;
      $display("A channel never carried a beat: rs %0d, ls fwd %0d, ls bwd %0d",
               n_rs, n_ls_fwd, n_ls_bwd);
    end
    $display("Error counts: value %0d, avail %0d, other %0d",
             val_errs, avail_errs, other_errs);
    if (val_errs + avail_errs + other_errs == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Watchdog sized from reset, table rows, gaps and line depth
  initial begin
    int          n_cyc;
    logic [15:0] wrow;
    n_cyc = RST_CYCLES;
    for (int i = 0; i < N_VEC; i++) begin
      wrow  = vector_row(i);
      n_cyc = n_cyc + 1 + wrow[3:0];
    end
    n_cyc = n_cyc + TOT_DEPTH + WD_MARGIN;
    #(n_cyc * CLK_PERIOD);
    $display("Timeout: run did not end within %0d cycles", n_cyc);
    $display("Regression failed");
    $finish;
  end

endmodule
